// ==== tb.f ====
hw/valu_pkg.sv
hw/lane_pkg.sv
hw/valu_mul.sv
hw/valu_lane.sv
hw/valu_top.sv
testbench/tb_clkgen.sv
testbench/tb_valu.sv

// ==== run.sh ====
#!/bin/sh
# Builds the vector ALU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_valu -o sim_valu
./obj_dir/sim_valu

// ==== testbench/tb_valu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_valu
   import valu_pkg::*;
   import lane_pkg::*;
();

   localparam int LANES = 4;
   localparam int BURST_CYCLES = 60;
   localparam int ISSUE_CYCLES = 2000;
   localparam int PIPE_DEPTH = 3;
   // Burst and issue cycles plus the drain plus a quarter of the issue length for stalls
   localparam int TIMEOUT_CYCLES = BURST_CYCLES + ISSUE_CYCLES + PIPE_DEPTH + ISSUE_CYCLES / 4;
   localparam logic [31:0] LFSR_SEED = 32'h1731;

   logic                   clk;
   logic                   rstn;
   logic                   stall;
   lane_req_t [LANES-1:0]  req;
   logic [LANES-1:0]       req_vld;
   lane_res_t [LANES-1:0]  res;
   logic [LANES-1:0]       res_vld;

   logic [31:0]            lfsr_state = LFSR_SEED;
   int unsigned            cycle_cnt = 0;
   lane_res_t              exp_q [LANES][$];
   logic [LANES-1:0][2:0]  mvld = '0;
   lane_res_t [LANES-1:0]  exp_out = '0;
   logic                   edge_stalled = 1'b0;

   tb_clkgen i_clkgen (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   valu_top #(
      .LANES (LANES)
   ) i_dut (
      .clk       (clk),
      .rstn      (rstn),
      .stall_i   (stall),
      .req_i     (req),
      .req_vld_i (req_vld),
      .res_o     (res),
      .res_vld_o (res_vld)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // Sign boundaries of every element width together with zero and all ones
   function automatic logic [31:0] edge_value(input logic [2:0] idx);
      case (idx)
         3'd0:    return 32'h0000_0080;
         3'd1:    return 32'h0000_007f;
         3'd2:    return 32'h0000_8000;
         3'd3:    return 32'h0000_7fff;
         3'd4:    return 32'h8000_0000;
         3'd5:    return 32'h7fff_ffff;
         3'd6:    return 32'hffff_ffff;
         default: return 32'h0000_0000;
      endcase
   endfunction

   function automatic logic [31:0] rand_operand();
      logic [2:0] kind;
      kind = 3'(rand_bits(3));
      case (kind)
         3'd0:       return 32'h0000_0000;
         3'd1:       return 32'hffff_ffff;
         3'd2, 3'd3: return edge_value(3'(rand_bits(3)));
         default:    return rand_bits(32);
      endcase
   endfunction

   function automatic lane_req_t rand_req();
      lane_req_t  r;
      logic [4:0] op_code;
      logic [1:0] sew_code;
      op_code = 5'(rand_bits(5));
      while (op_code >= 5'd20)
      begin
         op_code = 5'(rand_bits(5));
      end
      sew_code = 2'(rand_bits(2));
      while (sew_code == 2'd3)
      begin
         sew_code = 2'(rand_bits(2));
      end
      r.op = valu_op_e'(op_code);
      r.sew = sew_e'(sew_code);
      r.a = rand_operand();
      r.b = rand_operand();
      return r;
   endfunction

   // Expected lane output for one request
   function automatic lane_res_t model_result(input lane_req_t r);
      lane_res_t   res_m;
      int          w;
      logic [31:0] mask;
      logic [31:0] ea;
      logic [31:0] eb;
      logic [63:0] sa;
      logic [63:0] sb;
      logic [63:0] ma;
      logic [63:0] mb;
      logic [63:0] p;
      logic        a_signed;
      logic        b_signed;

      case (r.sew)
         sew8:
         begin
            w = 8;
            mask = 32'h0000_00ff;
         end
         sew16:
         begin
            w = 16;
            mask = 32'h0000_ffff;
         end
         default:
         begin
            w = 32;
            mask = 32'hffff_ffff;
         end
      endcase
      ea = r.a & mask;
      eb = r.b & mask;
      sa = {32'h0, ea};
      sb = {32'h0, eb};
      // Fill every bit above the element with its sign bit
      if (ea[w-1])
      begin
         sa = sa | ~{32'h0, mask};
      end
      if (eb[w-1])
      begin
         sb = sb | ~{32'h0, mask};
      end
      a_signed = r.op inside {mul_op, mulh_op, mulhsu_op, wmul_op, wmulsu_op};
      b_signed = r.op inside {mul_op, mulh_op, wmul_op};
      ma = a_signed ? sa : {32'h0, ea};
      mb = b_signed ? sb : {32'h0, eb};
      p = ma * mb;

      case (r.op)
         add_op:  res_m.data = (r.a + r.b) & mask;
         sub_op:  res_m.data = (r.a - r.b) & mask;
         xor_op:  res_m.data = (r.a ^ r.b) & mask;
         xnor_op: res_m.data = ~(r.a ^ r.b) & mask;
         and_op:  res_m.data = (r.a & r.b) & mask;
         nand_op: res_m.data = ~(r.a & r.b) & mask;
         or_op:   res_m.data = (r.a | r.b) & mask;
         nor_op:  res_m.data = ~(r.a | r.b) & mask;
         slt_op:  res_m.data = {31'h0, $signed(sa) < $signed(sb)};
         sgt_op:  res_m.data = {31'h0, $signed(sa) > $signed(sb)};
         seq_op:  res_m.data = {31'h0, ea == eb};
         sltu_op: res_m.data = {31'h0, ea < eb};
         sgtu_op: res_m.data = {31'h0, ea > eb};
         mul_op:  res_m.data = p[31:0] & mask;
         mulh_op, mulhu_op, mulhsu_op:
         begin
            res_m.data = 32'(p >> w) & mask;
         end
         default:
         begin
            res_m.data = (w == 8) ? {16'h0, p[15:0]} : p[31:0];
         end
      endcase
      return res_m;
   endfunction

   task automatic end_with_failure();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_res(input int lane, input lane_res_t exp, input lane_res_t act);
      if (exp !== act)
      begin
         $display("ERROR at %0d ns: res_o[%0d].data expected %h, got %h",
                  $time, lane, exp.data, act.data);
         end_with_failure();
      end
   endtask

   task automatic check_vld(input logic [LANES-1:0] exp, input logic [LANES-1:0] act);
      if (exp !== act)
      begin
         $display("ERROR at %0d ns: res_vld_o expected %b, got %b", $time, exp, act);
         end_with_failure();
      end
   endtask

   // Steps the model through this rising edge with the inputs that were in effect
   task automatic apply_edge();
      edge_stalled = stall;
      if (!stall)
      begin
         for (int l = 0; l < LANES; l++)
         begin
            // The stage 2 result is the queue head once the output has been consumed
            if (mvld[l][1])
            begin
               exp_out[l] = exp_q[l][0];
            end
            mvld[l] = {mvld[l][1:0], req_vld[l]};
            if (req_vld[l])
            begin
               exp_q[l].push_back(model_result(req[l]));
            end
         end
      end
   endtask

   task automatic check_outputs();
      logic [LANES-1:0] exp_vld;
      for (int l = 0; l < LANES; l++)
      begin
         exp_vld[l] = mvld[l][2];
      end
      check_vld(exp_vld, res_vld);
      for (int l = 0; l < LANES; l++)
      begin
         if (edge_stalled)
         begin
            check_res(l, exp_out[l], res[l]);
         end
         if (res_vld[l])
         begin
            if (exp_q[l].size() == 0)
            begin
               $display("Lane %0d presented a result at %0d ns with none outstanding",
                        l, $time);
               end_with_failure();
            end
            else
            begin
               check_res(l, exp_q[l][0], res[l]);
               // The result leaves the lane only on a non-stalled edge
               if (!stall)
               begin
                  void'(exp_q[l].pop_front());
               end
            end
         end
      end
   endtask

   task automatic run_cycle(input logic stall_nxt,
                            input lane_req_t [LANES-1:0] req_nxt,
                            input logic [LANES-1:0] vld_nxt);
      @(posedge clk);
      apply_edge();
      stall <= stall_nxt;
      req <= req_nxt;
      req_vld <= vld_nxt;
      @(negedge clk);
      check_outputs();
   endtask

   function automatic logic queues_empty();
      for (int l = 0; l < LANES; l++)
      begin
         if (exp_q[l].size() != 0)
         begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   always @(posedge clk)
   begin
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
         end_with_failure();
      end
      else
      begin
         cycle_cnt <= cycle_cnt + 1;
      end
   end

   initial
   begin : stimulus
      lane_req_t [LANES-1:0] nxt_req;
      logic [LANES-1:0]      nxt_vld;
      logic                  nxt_stall;
      int                    k;

      stall = 1'b0;
      req = '0;
      req_vld = '0;

      wait (rstn == 1'b1);
      @(negedge clk);
      check_vld('0, res_vld);
      for (int l = 0; l < LANES; l++)
      begin
         check_res(l, '0, res[l]);
      end

      // Directed burst without stall walks every op through every SEW
      for (int i = 0; i < BURST_CYCLES; i++)
      begin
         for (int l = 0; l < LANES; l++)
         begin
            k = i * LANES + l;
            nxt_req[l].op = valu_op_e'(5'(k % 20));
            nxt_req[l].sew = sew_e'(2'((k / 20) % 3));
            nxt_req[l].a = edge_value(3'(k % 8));
            nxt_req[l].b = edge_value(3'((k * 3 + i) % 8));
            nxt_vld[l] = ((i % 5) != l);
         end
         run_cycle(1'b0, nxt_req, nxt_vld);
      end

      for (int i = 0; i < ISSUE_CYCLES; i++)
      begin
         for (int l = 0; l < LANES; l++)
         begin
            nxt_req[l] = rand_req();
            nxt_vld[l] = (rand_bits(2) != 32'd0);
         end
         nxt_stall = (rand_bits(7) < 32'd19);
         run_cycle(nxt_stall, nxt_req, nxt_vld);
      end

      do
      begin
         run_cycle(1'b0, nxt_req, '0);
      end
      while (mvld != '0);

      if (queues_empty())
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
      begin
         $display("Results still outstanding after the pipeline drained");
         end_with_failure();
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
   output logic clk_o,
   output logic rstn_o
);

   localparam time HALF_PERIOD = 5ns;

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

   // Reset spans the first two rising edges
   initial
   begin
      rstn_o = 1'b0;
      repeat (2) @(posedge clk_o);
      rstn_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== hw/valu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_top
   import lane_pkg::*;
#(
   parameter int LANES = 4
)
(
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   stall_i,
   input  wire lane_req_t [LANES-1:0]  req_i,
   input  wire logic [LANES-1:0]       req_vld_i,
   output wire lane_res_t [LANES-1:0]  res_o,
   output wire logic [LANES-1:0]       res_vld_o
);

   // Lanes are independent apart from the shared stall
   for (genvar g = 0; g < LANES; g++)
   begin : g_lane
      valu_lane i_lane (
         .clk       (clk),
         .rstn      (rstn),
         .stall_i   (stall_i),
         .req_i     (req_i[g]),
         .req_vld_i (req_vld_i[g]),
         .res_o     (res_o[g]),
         .res_vld_o (res_vld_o[g])
      );
   end

endmodule

`default_nettype wire

// ==== hw/valu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_lane
   import valu_pkg::*;
   import lane_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rstn,
   input  wire logic       stall_i,
   input  wire lane_req_t  req_i,
   input  wire logic       req_vld_i,
   output lane_res_t       res_o,
   output logic            res_vld_o
);

   logic              adv;
   logic              s2_en;
   logic [2:0]        vld_q;
   lane_req_t         s1_q;
   valu_op_e          s2_op_q;
   sew_e              s2_sew_q;
   logic [XLEN-1:0]   alu_d;
   logic [XLEN-1:0]   s2_alu_q;
   logic [PROD_W-1:0] prod;
   logic [XLEN-1:0]   res_d;
   logic              cmp_sgn;
   logic [MUL_W-1:0]  cmp_a;
   logic [MUL_W-1:0]  cmp_b;
   logic              lt;
   logic              gt;

   assign adv = !stall_i;
   assign s2_en = adv && vld_q[0];

   // Valid pipe, bit 2 is the output stage
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_q <= '0;
      end
      else if (adv)
      begin
         vld_q <= {vld_q[1:0], req_vld_i};
      end
   end

   always_ff @(posedge clk)
   begin
      if (adv && req_vld_i)
      begin
         s1_q <= req_i;
      end
   end

   // Compares work on the SEW-wide element, extended by the signedness of the op
   assign cmp_sgn = (s1_q.op == slt_op) || (s1_q.op == sgt_op);
   assign cmp_a = sew_extend(s1_q.a, s1_q.sew, cmp_sgn);
   assign cmp_b = sew_extend(s1_q.b, s1_q.sew, cmp_sgn);
   assign lt = $signed(cmp_a) < $signed(cmp_b);
   assign gt = $signed(cmp_a) > $signed(cmp_b);

   // Add and logic run full width, the upper bits are cut off in stage 3
   always_comb
   begin
      case (s1_q.op)
         add_op:           alu_d = s1_q.a + s1_q.b;
         sub_op:           alu_d = s1_q.a - s1_q.b;
         xor_op:           alu_d = s1_q.a ^ s1_q.b;
         xnor_op:          alu_d = ~(s1_q.a ^ s1_q.b);
         and_op:           alu_d = s1_q.a & s1_q.b;
         nand_op:          alu_d = ~(s1_q.a & s1_q.b);
         or_op:            alu_d = s1_q.a | s1_q.b;
         nor_op:           alu_d = ~(s1_q.a | s1_q.b);
         slt_op, sltu_op:  alu_d = {{(XLEN-1){1'b0}}, lt};
         sgt_op, sgtu_op:  alu_d = {{(XLEN-1){1'b0}}, gt};
         seq_op:           alu_d = {{(XLEN-1){1'b0}}, cmp_a == cmp_b};
         default:          alu_d = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (s2_en)
      begin
         s2_op_q  <= s1_q.op;
         s2_sew_q <= s1_q.sew;
         s2_alu_q <= alu_d;
      end
   end

   // The product register sits in stage 2 beside the logic result
   valu_mul i_mul (
      .clk    (clk),
      .rstn   (rstn),
      .en_i   (s2_en),
      .op_i   (s1_q.op),
      .sew_i  (s1_q.sew),
      .a_i    (s1_q.a),
      .b_i    (s1_q.b),
      .prod_o (prod)
   );

   always_comb
   begin
      case (s2_op_q)
         mul_op:
         begin
            res_d = prod[XLEN-1:0] & sew_mask(s2_sew_q);
         end
         mulh_op, mulhu_op, mulhsu_op:
         begin
            case (s2_sew_q)
               sew8:    res_d = {{(XLEN-8){1'b0}}, prod[15:8]};
               sew16:   res_d = {{(XLEN-16){1'b0}}, prod[31:16]};
               default: res_d = prod[PROD_W-1:XLEN];
            endcase
         end
         wmul_op, wmulu_op, wmulsu_op:
         begin
            // Double width, but never more than one XLEN word
            if (s2_sew_q == sew8)
            begin
               res_d = {{(XLEN-16){1'b0}}, prod[15:0]};
            end
            else
            begin
               res_d = prod[XLEN-1:0];
            end
         end
         default:
         begin
            res_d = s2_alu_q & sew_mask(s2_sew_q);
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         res_o <= '0;
      end
      else if (adv && vld_q[1])
      begin
         res_o.data <= res_d;
      end
   end

   assign res_vld_o = vld_q[2];

   a_vld_latency: assert property (@(posedge clk) disable iff (!rstn)
      (vld_q[0] && !stall_i) ##1 !stall_i |=> res_vld_o)
      else $error("valu_lane: stage 1 valid did not reach the output in two cycles");

   a_vld_reset: assert property (@(posedge clk)
      !rstn |=> !res_vld_o)
      else $error("valu_lane: result valid high right after reset");

endmodule

`default_nettype wire

// ==== hw/valu_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_mul
   import valu_pkg::*;
(
   input  wire logic             clk,
   input  wire logic             rstn,
   input  wire logic             en_i,
   input  wire valu_op_e         op_i,
   input  wire sew_e             sew_i,
   input  wire logic [XLEN-1:0]  a_i,
   input  wire logic [XLEN-1:0]  b_i,
   output logic [PROD_W-1:0]     prod_o
);

   logic                      a_sgn;
   logic                      b_sgn;
   logic [MUL_W-1:0]          a_ext;
   logic [MUL_W-1:0]          b_ext;
   logic signed [2*MUL_W-1:0] prod_full;

   // Operand a is signed for the signed-by-unsigned forms as well
   assign a_sgn = op_i inside {mul_op, mulh_op, wmul_op, mulhsu_op, wmulsu_op};
   assign b_sgn = op_i inside {mul_op, mulh_op, wmul_op};

   assign a_ext = sew_extend(a_i, sew_i, a_sgn);
   assign b_ext = sew_extend(b_i, sew_i, b_sgn);

   // With the guard bit a single signed multiply covers every sign combination
   assign prod_full = $signed(a_ext) * $signed(b_ext);

   always_ff @(posedge clk)
   begin
      if (en_i)
      begin
         prod_o <= prod_full[PROD_W-1:0];
      end
   end

   a_prod_hold: assert property (@(posedge clk) disable iff (!rstn)
      !en_i |=> $stable(prod_o))
      else $error("valu_mul: product changed while stage was disabled");

endmodule

`default_nettype wire

// ==== hw/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

   import valu_pkg::*;

   // One element operation issued to a lane, 71 bits
   typedef struct packed {
      valu_op_e        op;
      sew_e            sew;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
   } lane_req_t;

   // Formatted element result
   typedef struct packed {
      logic [XLEN-1:0] data;
   } lane_res_t;

endpackage

`default_nettype wire

// ==== hw/valu_pkg.sv ====
`default_nettype none

package valu_pkg;

   localparam int XLEN = 32;
   // Multiplier operands carry one extra bit so signed and unsigned share one array
   localparam int MUL_W = XLEN + 1;
   localparam int PROD_W = 2 * XLEN;

   typedef enum logic [4:0] {
      add_op,
      sub_op,
      xor_op,
      xnor_op,
      and_op,
      nand_op,
      or_op,
      nor_op,
      slt_op,
      sgt_op,
      seq_op,
      sltu_op,
      sgtu_op,
      mul_op,
      mulh_op,
      mulhu_op,
      mulhsu_op,
      wmul_op,
      wmulu_op,
      wmulsu_op
   } valu_op_e;

   typedef enum logic [1:0] {
      sew8  = 2'b00,
      sew16 = 2'b01,
      sew32 = 2'b10
   } sew_e;

   // Live element bits for a given SEW
   function automatic logic [XLEN-1:0] sew_mask(input sew_e sew);
      case (sew)
         sew8:    return 32'h0000_00ff;
         sew16:   return 32'h0000_ffff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   // Extends the low SEW bits of an operand, sign or zero by sgn
   function automatic logic [MUL_W-1:0] sew_extend(input logic [XLEN-1:0] v,
                                                   input sew_e sew,
                                                   input logic sgn);
      logic [MUL_W-1:0] r;
      case (sew)
         sew8:    r = {{(MUL_W-8){sgn & v[7]}}, v[7:0]};
         sew16:   r = {{(MUL_W-16){sgn & v[15]}}, v[15:0]};
         default: r = {sgn & v[XLEN-1], v};
      endcase
      return r;
   endfunction

endpackage

`default_nettype wire
